//--- striped_mem.f
+incdir+include
rtl/stripe_pkg.sv
rtl/skid_buffer.sv
rtl/sync_fifo.sv
rtl/stripe_split.sv
rtl/stripe_write.sv
rtl/bank_mem.sv
rtl/striped_mem.sv
verif/striped_mem_tb.sv

//--- Bender.yml
package:
  name: striped_mem

sources:
  - include_dirs:
      - include
    files:
      - rtl/stripe_pkg.sv
      - rtl/skid_buffer.sv
      - rtl/sync_fifo.sv
      - rtl/stripe_split.sv
      - rtl/stripe_write.sv
      - rtl/bank_mem.sv
      - rtl/striped_mem.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/striped_mem_tb.sv

//--- verif/striped_mem_tb.sv
`include "stripe_config.svh"

module striped_mem_tb import stripe_pkg::*; ();

  localparam int NUM_S     = `STRIPE_NUM_S;
  localparam int DW        = `STRIPE_DATA_W;
  localparam int BPW       = DW / 8;
  localparam int OW        = $clog2(BPW);
  localparam int ABITS     = `STRIPE_ADDR_W;
  localparam int WORDS     = 2 ** (ABITS - OW);
  // upper bound on beats issued over all tests
  localparam int MAX_BEATS = NUM_S + 12 * 16 + 4 * 16 + 6 * 16 + 10 * 16 + 12 * 16;
  localparam int WATCHDOG_CYCLES = MAX_BEATS * 40 + 2000;

  logic                clk;
  logic                rst_n;
  aw_t                 i_aw;
  logic                i_aw_valid;
  logic                o_aw_ready;
  w_t                  i_w;
  logic                i_w_valid;
  logic                o_w_ready;
  b_t                  o_b;
  logic                o_b_valid;
  logic                i_b_ready;
  logic [ABITS-OW-1:0] i_rd_addr;
  logic [DW-1:0]       o_rd_data;

  integer                  seed;
  logic [DW-1:0]           model [WORDS];
  bit                      touched [WORDS];
  b_t                      exp_q [$];
  logic [`STRIPE_ID_W-1:0] next_id;
  bit                      b_stall;
  int                      stall_left;

  striped_mem striped_mem_i (.*);

  always #50 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // expected word after a strobed write over the current model contents
  function automatic logic [DW-1:0] model_word(input int w, input logic [DW-1:0] data,
                                               input logic [BPW-1:0] strb);
    logic [DW-1:0] word;
    word = model[w];
    for (int j = 0; j < BPW; j++) begin
      if (strb[j]) begin
        word[8*j +: 8] = data[8*j +: 8];
      end
    end
    return word;
  endfunction

  task automatic check_b(input b_t got, input b_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH o_b: got id %h resp %h, expected id %h resp %h",
                               got.id, got.resp, exp.id, exp.resp));
    end
  endtask

  task automatic check_rd(input int w, input logic [DW-1:0] got, input logic [DW-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH o_rd_data at word %h: got %h expected %h",
                               w, got, exp));
    end
  endtask

  // every stimulus task starts and ends 5 units after a rising edge
  task automatic write_burst(input int word, input int beats, input bit rand_strb,
                             input bit gaps);
    aw_t aw;
    w_t  wb;
    b_t  exp;
    aw.id    = next_id;
    aw.addr  = ABITS'(word * BPW);
    aw.len   = 8'(beats - 1);
    aw.size  = 3'(OW);
    aw.burst = 2'b01;
    exp.id   = next_id;
    exp.resp = 2'b00;
    exp_q.push_back(exp);
    next_id++;
    i_aw       = aw;
    i_aw_valid = 1'b1;
    @(negedge clk);
    while (!o_aw_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #5;
    i_aw_valid = 1'b0;
    for (int b = 0; b < beats; b++) begin
      if (gaps && rand_below(3) == 0) begin
        i_w_valid = 1'b0;
        repeat (1 + rand_below(3)) begin
          @(posedge clk);
          #5;
        end
      end
      wb.data = DW'($random(seed));
      wb.strb = rand_strb ? BPW'($random(seed)) : {BPW{1'b1}};
      wb.last = (b == beats - 1);
      model[word + b]   = model_word(word + b, wb.data, wb.strb);
      touched[word + b] = 1'b1;
      i_w       = wb;
      i_w_valid = 1'b1;
      @(negedge clk);
      while (!o_w_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #5;
    end
    i_w_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #5;
    end
  endtask

  // the address moves on right after the sampling edge so that only the
  // read register can still show the requested word
  task automatic read_word(input int w, output logic [DW-1:0] data);
    i_rd_addr = w[ABITS-OW-1:0];
    @(posedge clk);
    #5;
    i_rd_addr = ~i_rd_addr;
    @(negedge clk);
    data = o_rd_data;
    @(posedge clk);
    #5;
  endtask

  task automatic readback(input int lo, input int hi);
    logic [DW-1:0] got;
    for (int w = lo; w <= hi; w++) begin
      if (touched[w]) begin
        read_word(w, got);
        check_rd(w, got, model[w]);
      end
    end
  endtask

  // ------------------------------
  // response side
  // ------------------------------
  initial begin : b_ready_driver
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #5;
      if (!b_stall) begin
        stall_left = 0;
        i_b_ready  = 1'b1;
      end else if (stall_left > 0) begin
        stall_left--;
        i_b_ready = 1'b0;
      end else if (rand_below(8) == 0) begin
        // long enough stretches to back up the response FIFO
        stall_left = 4 + rand_below(40);
        i_b_ready  = 1'b0;
      end else begin
        i_b_ready = 1'b1;
      end
    end
  end

  initial begin : b_monitor
    b_t exp;
    forever begin
      @(negedge clk);
      if (o_b_valid && i_b_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("a write response arrived with no burst outstanding");
        end else begin
          exp = exp_q.pop_front();
          check_b(o_b, exp);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) begin
      @(posedge clk);
    end
    report_failure("timeout, the run did not finish within its cycle budget");
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : main
    int beats;
    int base;
    clk        = 1'b0;
    rst_n      = 1'b0;
    i_aw       = '0;
    i_aw_valid = 1'b0;
    i_w        = '0;
    i_w_valid  = 1'b0;
    i_b_ready  = 1'b0;
    i_rd_addr  = '0;
    seed       = 18;
    next_id    = '0;
    b_stall    = 1'b0;
    stall_left = 0;
    repeat (10) begin
      @(posedge clk);
    end
    #5;
    rst_n = 1'b1;
    @(posedge clk);
    #5;
    if (o_b_valid !== 1'b0) begin
      report_failure($sformatf("MISMATCH o_b_valid: got %h expected %h", o_b_valid, 1'b0));
    end

    // one single-beat write per bank
    for (int w = 0; w < NUM_S; w++) begin
      write_burst(w, 1, 1'b0, 1'b0);
    end
    drain();
    readback(0, NUM_S - 1);

    // random bursts with full strobes
    for (int n = 0; n < 12; n++) begin
      beats = 1 + rand_below(16);
      base  = rand_below(256 - beats + 1);
      write_burst(base, beats, 1'b0, 1'b0);
    end
    drain();
    readback(0, 255);

    // prefill words 512 to 575, then rewrite them under random strobes
    for (int n = 0; n < 4; n++) begin
      write_burst(512 + 16 * n, 16, 1'b0, 1'b0);
    end
    drain();
    for (int n = 0; n < 6; n++) begin
      beats = 1 + rand_below(16);
      base  = 512 + rand_below(64 - beats + 1);
      write_burst(base, beats, 1'b1, 1'b0);
    end
    drain();
    readback(512, 575);

    // responses in order while the response channel stalls
    b_stall = 1'b1;
    for (int n = 0; n < 10; n++) begin
      beats = 1 + rand_below(16);
      base  = rand_below(256 - beats + 1);
      write_burst(base, beats, 1'b0, 1'b0);
    end
    drain();
    readback(0, 255);

    // back to back bursts with gaps on the data channel
    for (int n = 0; n < 12; n++) begin
      beats = 1 + rand_below(16);
      base  = 512 + rand_below(64 - beats + 1);
      write_burst(base, beats, 1'b1, 1'b1);
    end
    drain();
    readback(512, 575);

    // idle a while so a stray extra response would still be caught
    b_stall = 1'b0;
    repeat (30) begin
      @(posedge clk);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- rtl/striped_mem.sv
`include "stripe_config.svh"

module striped_mem import stripe_pkg::*; (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  aw_t                                               i_aw,
  input  logic                                              i_aw_valid,
  output logic                                              o_aw_ready,
  input  w_t                                                i_w,
  input  logic                                              i_w_valid,
  output logic                                              o_w_ready,
  output b_t                                                o_b,
  output logic                                              o_b_valid,
  input  logic                                              i_b_ready,
  input  logic [`STRIPE_ADDR_W-$clog2(`STRIPE_DATA_W/8)-1:0] i_rd_addr,
  output logic [`STRIPE_DATA_W-1:0]                         o_rd_data
);

  localparam int NUM_S = `STRIPE_NUM_S;
  localparam int OW    = $clog2(`STRIPE_DATA_W / 8);

  bank_aw_t [NUM_S-1:0]                   m_aw;
  logic [NUM_S-1:0]                       m_aw_valid;
  logic [NUM_S-1:0]                       m_aw_ready;
  w_t [NUM_S-1:0]                         m_w;
  logic [NUM_S-1:0]                       m_w_valid;
  logic [NUM_S-1:0]                       m_w_ready;
  b_t [NUM_S-1:0]                         m_b;
  logic [NUM_S-1:0]                       m_b_valid;
  logic [NUM_S-1:0]                       m_b_ready;
  logic [NUM_S-1:0][`STRIPE_DATA_W-1:0]   rd_data;
  addr_u                                  rd_addr;
  bank_idx_t                              rd_bank;

  stripe_write stripe_write_i (
    .clk(clk), .rst_n(rst_n),
    .i_aw(i_aw), .i_aw_valid(i_aw_valid), .o_aw_ready(o_aw_ready),
    .i_w(i_w), .i_w_valid(i_w_valid), .o_w_ready(o_w_ready),
    .o_b(o_b), .o_b_valid(o_b_valid), .i_b_ready(i_b_ready),
    .o_m_aw(m_aw), .o_m_aw_valid(m_aw_valid), .i_m_aw_ready(m_aw_ready),
    .o_m_w(m_w), .o_m_w_valid(m_w_valid), .i_m_w_ready(m_w_ready),
    .i_m_b(m_b), .i_m_b_valid(m_b_valid), .o_m_b_ready(m_b_ready)
  );

  // the read word address splits into a bank and a row within it
  assign rd_addr.flat = {i_rd_addr, {OW{1'b0}}};

  for (genvar i = 0; i < NUM_S; i++) begin : gen_bank
    bank_mem bank_i (
      .clk(clk), .rst_n(rst_n),
      .i_aw(m_aw[i]), .i_aw_valid(m_aw_valid[i]), .o_aw_ready(m_aw_ready[i]),
      .i_w(m_w[i]), .i_w_valid(m_w_valid[i]), .o_w_ready(m_w_ready[i]),
      .o_b(m_b[i]), .o_b_valid(m_b_valid[i]), .i_b_ready(m_b_ready[i]),
      .i_rd_row(rd_addr.f.row), .o_rd_data(rd_data[i])
    );
  end

  // banks read on the clock edge, so the select is delayed to match
  always_ff @(posedge clk) begin
    rd_bank <= rd_addr.f.bank;
  end

  assign o_rd_data = rd_data[rd_bank];

endmodule

//--- rtl/bank_mem.sv
`include "stripe_config.svh"

module bank_mem import stripe_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  bank_aw_t                       i_aw,
  input  logic                           i_aw_valid,
  output logic                           o_aw_ready,
  input  w_t                             i_w,
  input  logic                           i_w_valid,
  output logic                           o_w_ready,
  output b_t                             o_b,
  output logic                           o_b_valid,
  input  logic                           i_b_ready,
  input  logic [`STRIPE_BANK_ROWS_W-1:0] i_rd_row,
  output logic [`STRIPE_DATA_W-1:0]      o_rd_data
);

  localparam int RW = `STRIPE_BANK_ROWS_W;
  localparam int OW = $clog2(`STRIPE_DATA_W / 8);

  logic [`STRIPE_DATA_W-1:0] mem [2**RW];

  logic                      active;
  logic [RW-1:0]             row;
  logic [7:0]                beat_cnt;
  logic [7:0]                len;
  logic [`STRIPE_ID_W-1:0]   id;
  logic                      err;
  logic                      w_fire;
  logic                      final_beat;
  logic                      bad_last;

  // one burst at a time, a new address waits until the response is taken
  assign o_aw_ready = !active && !o_b_valid;
  assign o_w_ready  = active;
  assign w_fire     = i_w_valid && active;
  assign final_beat = (beat_cnt == len);
  assign bad_last   = (i_w.last != final_beat);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      o_b_valid <= 1'b0;
    end else begin
      if (i_aw_valid && o_aw_ready) begin
        active <= 1'b1;
      end else if (w_fire && final_beat) begin
        active <= 1'b0;
      end
      if (w_fire && final_beat) begin
        o_b_valid <= 1'b1;
      end else if (i_b_ready) begin
        o_b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_aw_valid && o_aw_ready) begin
      row      <= i_aw.addr[OW +: RW];
      len      <= i_aw.len;
      id       <= i_aw.id;
      beat_cnt <= '0;
      err      <= 1'b0;
    end else if (w_fire) begin
      row      <= row + 1'b1;
      beat_cnt <= beat_cnt + 1'b1;
      err      <= err | bad_last;
      // SLVERR when the last flag does not line up with len
      if (final_beat) begin
        o_b <= '{id, (err | bad_last) ? 2'b10 : 2'b00};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_fire) begin
      for (int j = 0; j < `STRIPE_DATA_W / 8; j++) begin
        if (i_w.strb[j]) begin
          mem[row][8*j +: 8] <= i_w.data[8*j +: 8];
        end
      end
    end
    o_rd_data <= mem[i_rd_row];
  end

endmodule

//--- rtl/stripe_write.sv
`include "stripe_config.svh"

module stripe_write import stripe_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  aw_t                              i_aw,
  input  logic                             i_aw_valid,
  output logic                             o_aw_ready,
  input  w_t                               i_w,
  input  logic                             i_w_valid,
  output logic                             o_w_ready,
  output b_t                               o_b,
  output logic                             o_b_valid,
  input  logic                             i_b_ready,
  output bank_aw_t [`STRIPE_NUM_S-1:0]     o_m_aw,
  output logic [`STRIPE_NUM_S-1:0]         o_m_aw_valid,
  input  logic [`STRIPE_NUM_S-1:0]         i_m_aw_ready,
  output w_t [`STRIPE_NUM_S-1:0]           o_m_w,
  output logic [`STRIPE_NUM_S-1:0]         o_m_w_valid,
  input  logic [`STRIPE_NUM_S-1:0]         i_m_w_ready,
  input  b_t [`STRIPE_NUM_S-1:0]           i_m_b,
  input  logic [`STRIPE_NUM_S-1:0]         i_m_b_valid,
  output logic [`STRIPE_NUM_S-1:0]         o_m_b_ready
);

  localparam int NUM_S = `STRIPE_NUM_S;
  localparam int BAW   = `STRIPE_ADDR_W - $clog2(NUM_S);

  typedef struct packed {
    bank_idx_t  start;
    logic [7:0] len;
  } w_ent_t;

  typedef struct packed {
    bank_idx_t        last_bank;
    logic [NUM_S-1:0] mask;
  } b_ent_t;

  aw_t                         sb_aw;
  logic                        sb_aw_valid;
  logic                        sb_aw_ready;
  logic                        aw_acc;
  logic [NUM_S-1:0]            split_valid;
  logic [NUM_S-1:0][BAW-1:0]   split_addr;
  logic [NUM_S-1:0][7:0]       split_len;
  bank_idx_t                   split_start;
  bank_idx_t                   split_end;

  w_ent_t                      wf_out;
  logic                        wf_full;
  logic                        wf_empty;
  logic                        wf_rd;
  b_ent_t                      bf_out;
  logic                        bf_full;
  logic                        bf_empty;
  logic                        bf_rd;

  w_t                          sb_w;
  logic                        sb_w_valid;
  logic                        sb_w_ready;
  logic                        w_active;
  bank_idx_t                   w_idx;
  bank_idx_t                   cur_idx;
  logic [7:0]                  w_remaining;
  logic [7:0]                  cur_rem;

  b_t [NUM_S-1:0]              sbm_b;
  logic [NUM_S-1:0]            sbm_b_valid;
  logic [NUM_S-1:0]            sbm_b_ready;
  b_t                          sb_b;
  logic                        sb_b_valid;
  logic                        sb_b_ready;

  // ------------------------------
  // address fan-out
  // ------------------------------
  skid_buffer #(.WIDTH($bits(aw_t))) aw_skid_i (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_aw_valid), .i_data(i_aw), .o_ready(o_aw_ready),
    .i_ready(sb_aw_ready), .o_data(sb_aw), .o_valid(sb_aw_valid)
  );

  // take a burst only when both FIFOs have room and no bank register is stuck
  assign sb_aw_ready = !wf_full && !bf_full && &(~o_m_aw_valid | i_m_aw_ready);
  assign aw_acc      = sb_aw_valid && sb_aw_ready;

  stripe_split split_i (
    .i_addr(sb_aw.addr), .i_len(sb_aw.len),
    .o_valid(split_valid), .o_addr(split_addr), .o_len(split_len),
    .o_start(split_start), .o_end(split_end)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_m_aw_valid <= '0;
    end else if (aw_acc) begin
      o_m_aw_valid <= split_valid;
    end else begin
      o_m_aw_valid <= o_m_aw_valid & ~i_m_aw_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_acc) begin
      for (int i = 0; i < NUM_S; i++) begin
        o_m_aw[i] <= '{sb_aw.id, split_addr[i], split_len[i], sb_aw.size, sb_aw.burst};
      end
    end
  end

  // ------------------------------
  // write-beat steering
  // ------------------------------
  sync_fifo #(.WIDTH($bits(w_ent_t)), .ADDR_W(`STRIPE_FIFO_AW)) w_fifo_i (
    .clk(clk), .rst_n(rst_n),
    .i_wr(aw_acc), .i_wr_data(w_ent_t'{split_start, sb_aw.len}), .o_full(wf_full),
    .i_rd(wf_rd), .o_rd_data(wf_out), .o_empty(wf_empty)
  );

  skid_buffer #(.WIDTH($bits(w_t))) w_skid_i (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_w_valid), .i_data(i_w), .o_ready(o_w_ready),
    .i_ready(sb_w_ready), .o_data(sb_w), .o_valid(sb_w_valid)
  );

  // the first beat of a burst takes its start bank and length from the FIFO head
  assign cur_idx    = w_active ? w_idx : wf_out.start;
  assign cur_rem    = w_active ? w_remaining : wf_out.len;
  assign sb_w_ready = (w_active || !wf_empty) &&
                      (!o_m_w_valid[cur_idx] || i_m_w_ready[cur_idx]);
  assign wf_rd      = sb_w_valid && sb_w_ready && !w_active;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_active    <= 1'b0;
      o_m_w_valid <= '0;
    end else begin
      o_m_w_valid <= o_m_w_valid & ~i_m_w_ready;
      if (sb_w_valid && sb_w_ready) begin
        o_m_w_valid[cur_idx] <= 1'b1;
        w_active             <= (cur_rem != '0);
      end
    end
  end

  // a bank sees its last beat once fewer than NUM_S beats remain overall
  always_ff @(posedge clk) begin
    if (sb_w_valid && sb_w_ready) begin
      o_m_w[cur_idx] <= '{sb_w.data, sb_w.strb, cur_rem < NUM_S};
      w_idx          <= cur_idx + 1'b1;
      w_remaining    <= cur_rem - 1'b1;
    end
  end

  // ------------------------------
  // response collection
  // ------------------------------
  sync_fifo #(.WIDTH($bits(b_ent_t)), .ADDR_W(`STRIPE_FIFO_AW)) b_fifo_i (
    .clk(clk), .rst_n(rst_n),
    .i_wr(aw_acc), .i_wr_data(b_ent_t'{split_end, split_valid}), .o_full(bf_full),
    .i_rd(bf_rd), .o_rd_data(bf_out), .o_empty(bf_empty)
  );

  for (genvar i = 0; i < NUM_S; i++) begin : gen_b_skid
    skid_buffer #(.WIDTH($bits(b_t))) b_skid_i (
      .clk(clk), .rst_n(rst_n),
      .i_valid(i_m_b_valid[i]), .i_data(i_m_b[i]), .o_ready(o_m_b_ready[i]),
      .i_ready(sbm_b_ready[i]), .o_data(sbm_b[i]), .o_valid(sbm_b_valid[i])
    );
  end

  // wait for every participating bank so that no bank's response is left
  // behind to be mistaken for the next burst
  assign sb_b_valid  = !bf_empty && &(sbm_b_valid | ~bf_out.mask);
  assign sb_b        = sbm_b[bf_out.last_bank];
  assign bf_rd       = sb_b_valid && sb_b_ready;
  assign sbm_b_ready = bf_out.mask & {NUM_S{bf_rd}};

  skid_buffer #(.WIDTH($bits(b_t))) b_out_skid_i (
    .clk(clk), .rst_n(rst_n),
    .i_valid(sb_b_valid), .i_data(sb_b), .o_ready(sb_b_ready),
    .i_ready(i_b_ready), .o_data(o_b), .o_valid(o_b_valid)
  );

endmodule

//--- rtl/stripe_split.sv
`include "stripe_config.svh"

module stripe_split import stripe_pkg::*; (
  input  addr_u                     i_addr,
  input  logic [7:0]                i_len,
  output logic [`STRIPE_NUM_S-1:0]  o_valid,
  output logic [`STRIPE_NUM_S-1:0][`STRIPE_ADDR_W-$clog2(`STRIPE_NUM_S)-1:0] o_addr,
  output logic [`STRIPE_NUM_S-1:0][7:0] o_len,
  output bank_idx_t                 o_start,
  output bank_idx_t                 o_end
);

  localparam int SW = $clog2(`STRIPE_NUM_S);
  localparam int OW = $clog2(`STRIPE_DATA_W / 8);
  localparam int RW = `STRIPE_BANK_ROWS_W;

  // distance of a bank from the start bank, in beats
  bank_idx_t     k;
  logic [RW-1:0] row;

  always_comb begin
    o_start = i_addr.f.bank;
    o_end   = i_addr.f.bank + i_len[SW-1:0];
    for (int i = 0; i < `STRIPE_NUM_S; i++) begin
      k          = bank_idx_t'(i) - o_start;
      o_valid[i] = (8'(k) <= i_len);
      // this bank takes beats k, k+NUM_S, ... up to len
      o_len[i]   = (i_len - 8'(k)) >> SW;
      // banks below the start bank begin on the next row
      row        = i_addr.f.row + RW'(bank_idx_t'(i) < o_start);
      o_addr[i]  = {row, (k == '0) ? i_addr.f.offset : {OW{1'b0}}};
    end
  end

endmodule

//--- rtl/sync_fifo.sv
module sync_fifo #(
  parameter int WIDTH  = 8,
  parameter int ADDR_W = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_wr,
  input  logic [WIDTH-1:0] i_wr_data,
  output logic             o_full,
  input  logic             i_rd,
  output logic [WIDTH-1:0] o_rd_data,
  output logic             o_empty
);

  logic [WIDTH-1:0] mem [2**ADDR_W];

  // pointers carry one extra wrap bit to tell full from empty
  logic [ADDR_W:0]  wr_ptr;
  logic [ADDR_W:0]  rd_ptr;

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  // the head entry is always visible
  assign o_rd_data = mem[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_wr && !o_full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rd && !o_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_wr && !o_full) begin
      mem[wr_ptr[ADDR_W-1:0]] <= i_wr_data;
    end
  end

endmodule

//--- rtl/skid_buffer.sv
module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_ready,
  input  logic             i_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid
);

  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;

  // upstream ready comes straight from a flop, so the downstream ready
  // path never reaches the producer
  assign o_ready = !skid_valid;

  // the skid entry has priority, it always holds the older beat
  assign o_valid = skid_valid || i_valid;
  assign o_data  = skid_valid ? skid_data : i_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_valid <= 1'b0;
    end else if (i_valid && o_ready && !i_ready) begin
      skid_valid <= 1'b1;
    end else if (i_ready) begin
      skid_valid <= 1'b0;
    end
  end

  // capture the incoming beat when downstream stalls
  always_ff @(posedge clk) begin
    if (i_valid && o_ready && !i_ready) begin
      skid_data <= i_data;
    end
  end

endmodule

//--- rtl/stripe_pkg.sv
`include "stripe_config.svh"

package stripe_pkg;

  typedef logic [$clog2(`STRIPE_NUM_S)-1:0] bank_idx_t;

  // manager write address beat
  typedef struct packed {
    logic [`STRIPE_ID_W-1:0]   id;
    logic [`STRIPE_ADDR_W-1:0] addr;
    logic [7:0]                len;
    logic [2:0]                size;
    logic [1:0]                burst;
  } aw_t;

  typedef struct packed {
    logic [`STRIPE_DATA_W-1:0]   data;
    logic [`STRIPE_DATA_W/8-1:0] strb;
    logic                        last;
  } w_t;

  typedef struct packed {
    logic [`STRIPE_ID_W-1:0] id;
    logic [1:0]              resp;
  } b_t;

  // address beat seen by one bank, the bank index bits are stripped
  typedef struct packed {
    logic [`STRIPE_ID_W-1:0]                         id;
    logic [`STRIPE_ADDR_W-$clog2(`STRIPE_NUM_S)-1:0] addr;
    logic [7:0]                                      len;
    logic [2:0]                                      size;
    logic [1:0]                                      burst;
  } bank_aw_t;

  typedef struct packed {
    logic [`STRIPE_BANK_ROWS_W-1:0]        row;
    bank_idx_t                             bank;
    logic [$clog2(`STRIPE_DATA_W/8)-1:0]   offset;
  } addr_fields_t;

  // one byte address, seen flat or split into row, bank and byte offset
  typedef union packed {
    logic [`STRIPE_ADDR_W-1:0] flat;
    addr_fields_t              f;
  } addr_u;

endpackage

//--- include/stripe_config.svh
`ifndef STRIPE_CONFIG_SVH
`define STRIPE_CONFIG_SVH

// number of banks, must be a power of two
`define STRIPE_NUM_S 4

// byte address, data and transaction id widths
`define STRIPE_ADDR_W 12
`define STRIPE_DATA_W 32
`define STRIPE_ID_W 4

// log2 depth of the bookkeeping FIFOs in the stripe writer
`define STRIPE_FIFO_AW 3

// row address width of one bank, what is left after bank and byte offset bits
`define STRIPE_BANK_ROWS_W \
  (`STRIPE_ADDR_W - $clog2(`STRIPE_NUM_S) - $clog2(`STRIPE_DATA_W / 8))

`endif
